/* rtl/awg_pkg.sv */
// awg shared definitions
// sizes of the sample memories, the trigger mode encoding and the
// structs that carry the write port, channel config and transfer status

package awg_pkg;

  // channel and memory geometry
  localparam int channels = 2;
  localparam int chan_width = $clog2(channels);
  localparam int depth = 16;
  localparam int addr_width = 4;
  // one extra bit so a full-depth frame length of 16 fits
  localparam int depth_width = addr_width + 1;

  // sample word layout
  localparam int parallel_samples = 2;
  localparam int sample_width = 16;
  localparam int word_width = parallel_samples * sample_width;

  // frames per burst
  localparam int burst_width = 8;

  // read address to output register, both memory stages included
  localparam int read_latency = 3;

  typedef logic [word_width-1:0] sample_word_t;

  // per-channel trigger generation
  typedef enum logic [1:0] {
    trig_off         = 2'd0,
    trig_first_frame = 2'd1,
    trig_every_frame = 2'd2
  } trigger_mode_t;

  // stored as length minus one and frame count minus one
  typedef struct packed {
    logic [addr_width-1:0]  last_addr;
    trigger_mode_t          trig_mode;
    logic [burst_width-1:0] last_frame;
  } channel_cfg_t;

  typedef struct packed {
    logic                  en;
    logic [chan_width-1:0] chan;
    logic [addr_width-1:0] addr;
    sample_word_t          data;
  } write_port_t;

  typedef struct packed {
    logic early_last;
    logic missing_last;
  } transfer_status_t;

endpackage

/* rtl/awg_loader.sv */
// awg loader
// holds the channel configuration, runs the idle / accepting / blocking
// load FSM, steps the write pointer through addresses and channels and
// checks where the last flag of the waveform stream lands

`timescale 1ns/1ps

module awg_loader import awg_pkg::*; (
  input  logic                                   dac_clk,
  input  logic                                   dma_reset,
  input  logic                                   depth_valid,
  input  logic [channels-1:0][depth_width-1:0]   depth_lengths,
  input  logic                                   trig_valid,
  input  trigger_mode_t [channels-1:0]           trig_modes,
  input  logic                                   burst_valid,
  input  logic [channels-1:0][burst_width-1:0]   burst_lengths,
  input  logic                                   stop,
  input  logic                                   play_done,
  input  logic                                   in_valid,
  input  logic                                   in_last,
  input  sample_word_t                           in_data,
  output logic                                   cfg_ready,
  output logic                                   in_ready,
  output write_port_t                            wr,
  output channel_cfg_t [channels-1:0]            cfg,
  output transfer_status_t                       status,
  output logic                                   status_valid,
  input  logic                                   status_ack
);

  typedef enum logic [1:0] {ld_idle, ld_accepting, ld_blocking} load_state_t;

  load_state_t           state;
  logic                  accept;
  logic                  depth_ok;
  logic                  at_chan_end;
  logic                  at_final;
  // next free slot of the incoming stream
  logic [addr_width-1:0] ptr_addr;
  logic [chan_width-1:0] ptr_chan;
  logic [channels-1:0]   chan_full;
  // accepted word, one cycle behind
  logic                  acc_q;
  logic                  last_q;
  logic                  final_q;

  assign cfg_ready = (state == ld_idle);
  assign in_ready  = (state == ld_accepting);
  assign accept    = in_valid & in_ready;
  assign depth_ok  = depth_valid & cfg_ready;

  assign at_chan_end = (ptr_addr == cfg[ptr_chan].last_addr);
  assign at_final    = at_chan_end & (ptr_chan == chan_width'(channels - 1));

  ////////////////////////////////////////////////////////////////////////////
  // load FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge dac_clk) begin
    if (dma_reset) begin
      state <= ld_idle;
    end else begin
      case (state)
        ld_idle: begin
          if (depth_valid) begin
            state <= ld_accepting;
          end
        end
        ld_accepting: begin
          // a last flag or a full final frame closes the transfer
          if (accept && (in_last || at_final)) begin
            state <= ld_blocking;
          end
        end
        default: begin
          if (stop || play_done) begin
            state <= ld_idle;
          end
        end
      endcase
    end
  end

  // config strobes only land while idle
  always_ff @(posedge dac_clk) begin
    if (dma_reset) begin
      cfg <= '0;
    end else begin
      for (int ch = 0; ch < channels; ch++) begin
        if (depth_ok) begin
          cfg[ch].last_addr <= addr_width'(depth_lengths[ch] - 1'b1);
        end
        if (trig_valid && cfg_ready) begin
          cfg[ch].trig_mode <= trig_modes[ch];
        end
        if (burst_valid && cfg_ready) begin
          cfg[ch].last_frame <= burst_lengths[ch] - 1'b1;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // write pointer and registered write port
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge dac_clk) begin
    wr.data <= in_data;
    wr.addr <= ptr_addr;
    wr.chan <= ptr_chan;
    last_q  <= in_last;
    final_q <= at_final;
    if (dma_reset) begin
      wr.en     <= 1'b0;
      acc_q     <= 1'b0;
      ptr_addr  <= '0;
      ptr_chan  <= '0;
      chan_full <= '0;
    end else begin
      acc_q <= accept;
      // nothing more goes into a channel whose frame is full
      wr.en <= accept & ~chan_full[ptr_chan];
      if (state == ld_idle) begin
        ptr_addr  <= '0;
        ptr_chan  <= '0;
        chan_full <= '0;
      end else if (accept) begin
        if (at_chan_end) begin
          ptr_addr            <= '0;
          chan_full[ptr_chan] <= 1'b1;
          if (ptr_chan == chan_width'(channels - 1)) begin
            ptr_chan <= '0;
          end else begin
            ptr_chan <= ptr_chan + 1'b1;
          end
        end else begin
          ptr_addr <= ptr_addr + 1'b1;
        end
      end
    end
  end

  // transfer status, judged on the word just written
  always_ff @(posedge dac_clk) begin
    if (dma_reset) begin
      status       <= '0;
      status_valid <= 1'b0;
    end else if (depth_ok) begin
      // new transfer starts with a clean status
      status       <= '0;
      status_valid <= 1'b0;
    end else begin
      if (status_ack) begin
        status_valid <= 1'b0;
      end
      if (acc_q) begin
        if (final_q) begin
          status_valid <= 1'b1;
          if (!last_q) begin
            status.missing_last <= 1'b1;
          end else begin
            status <= '0;
          end
        end else if (last_q) begin
          // last came before the final address
          status.early_last <= 1'b1;
          status_valid      <= 1'b1;
        end
      end
    end
  end

endmodule

/* rtl/awg_sample_buffer.sv */
// awg sample buffer
// one sample memory per channel, written through the loader write port
// and read on all channels at once through two register stages, then an
// output register that forces masked channels to zero

`timescale 1ns/1ps

module awg_sample_buffer import awg_pkg::*; (
  input  logic                                  dac_clk,
  input  write_port_t                           wr,
  input  logic [channels-1:0][addr_width-1:0]   read_addr,
  input  logic [channels-1:0]                   zero_mask,
  output sample_word_t [channels-1:0]           dac_data
);

  // last memory stage of each channel
  sample_word_t [channels-1:0] rd_tail;

  for (genvar ch = 0; ch < channels; ch++) begin : gen_chan
    sample_word_t mem [depth];
    // stage 0 is the memory read register
    sample_word_t stage_q [read_latency-1];

    always_ff @(posedge dac_clk) begin
      if (wr.en && (wr.chan == chan_width'(ch))) begin
        mem[wr.addr] <= wr.data;
      end
    end

    always_ff @(posedge dac_clk) begin
      stage_q[0] <= mem[read_addr[ch]];
      for (int s = 1; s < read_latency - 1; s++) begin
        stage_q[s] <= stage_q[s-1];
      end
    end

    assign rd_tail[ch] = stage_q[read_latency-2];
  end

  // zero the channels that are done or idle
  always_ff @(posedge dac_clk) begin
    for (int ch = 0; ch < channels; ch++) begin
      if (zero_mask[ch]) begin
        dac_data[ch] <= '0;
      end else begin
        dac_data[ch] <= rd_tail[ch];
      end
    end
  end

endmodule

/* rtl/awg_playback.sv */
// awg playback
// idle / active FSM that walks each channel's read address over its
// frame, counts frames of the burst, flags finished channels and makes
// the trigger pulses, delayed to line up with the buffer output

`timescale 1ns/1ps

module awg_playback import awg_pkg::*; (
  input  logic                                  dac_clk,
  input  logic                                  dma_reset,
  input  logic                                  start,
  input  logic                                  stop,
  input  channel_cfg_t [channels-1:0]           cfg,
  output logic [channels-1:0][addr_width-1:0]   read_addr,
  output logic [channels-1:0]                   zero_mask,
  output logic [channels-1:0]                   dac_trigger,
  output logic                                  dac_valid,
  output logic                                  play_done
);

  typedef enum logic {pb_idle, pb_active} play_state_t;

  play_state_t                           state;
  logic [channels-1:0][burst_width-1:0]  frame_q;
  logic [channels-1:0]                   done_q;
  logic [channels-1:0]                   live;
  logic [channels-1:0]                   at_last;
  logic [channels-1:0]                   trig_now;
  // mask needs one stage less, the buffer output register adds the last
  logic [read_latency-2:0][channels-1:0] mask_pipe;
  logic [read_latency-1:0][channels-1:0] trig_pipe;
  logic [read_latency-1:0]               valid_pipe;

  assign zero_mask   = mask_pipe[read_latency-2];
  assign dac_trigger = trig_pipe[read_latency-1];
  assign dac_valid   = valid_pipe[read_latency-1];

  // per-channel address decode and trigger request
  always_comb begin
    for (int ch = 0; ch < channels; ch++) begin
      live[ch]     = (state == pb_active) & ~done_q[ch];
      at_last[ch]  = (read_addr[ch] == cfg[ch].last_addr);
      trig_now[ch] = 1'b0;
      if (live[ch] && (read_addr[ch] == '0)) begin
        case (cfg[ch].trig_mode)
          trig_every_frame: trig_now[ch] = 1'b1;
          trig_first_frame: trig_now[ch] = (frame_q[ch] == '0);
          default:          trig_now[ch] = 1'b0;
        endcase
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // playback FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge dac_clk) begin
    if (dma_reset) begin
      state     <= pb_idle;
      play_done <= 1'b0;
    end else begin
      play_done <= 1'b0;
      case (state)
        pb_idle: begin
          if (start) begin
            state <= pb_active;
          end
        end
        default: begin
          if (stop) begin
            state <= pb_idle;
          end else if (&done_q) begin
            // every channel finished its burst
            state     <= pb_idle;
            play_done <= 1'b1;
          end
        end
      endcase
    end
  end

  // read addresses, frame counters and done flags
  always_ff @(posedge dac_clk) begin
    if (dma_reset || (state == pb_idle)) begin
      read_addr <= '0;
      frame_q   <= '0;
      done_q    <= '0;
    end else begin
      for (int ch = 0; ch < channels; ch++) begin
        if (!done_q[ch]) begin
          if (at_last[ch]) begin
            read_addr[ch] <= '0;
            if (frame_q[ch] == cfg[ch].last_frame) begin
              done_q[ch] <= 1'b1;
            end else begin
              frame_q[ch] <= frame_q[ch] + 1'b1;
            end
          end else begin
            read_addr[ch] <= read_addr[ch] + 1'b1;
          end
        end
      end
    end
  end

  // align mask and trigger with the memory read path
  always_ff @(posedge dac_clk) begin
    if (dma_reset) begin
      mask_pipe  <= '1;
      trig_pipe  <= '0;
      valid_pipe <= '0;
    end else begin
      mask_pipe  <= {mask_pipe[read_latency-3:0], ~live};
      trig_pipe  <= {trig_pipe[read_latency-2:0], trig_now};
      valid_pipe <= {valid_pipe[read_latency-2:0], 1'b1};
    end
  end

endmodule

/* rtl/awg_top.sv */
// awg top level
// connects the loader, the sample buffer and the playback engine of the
// arbitrary waveform generator core

`timescale 1ns/1ps

module awg_top import awg_pkg::*; (
  input  logic                                  dac_clk,
  input  logic                                  dma_reset,
  input  logic                                  depth_valid,
  input  logic [channels-1:0][depth_width-1:0]  depth_lengths,
  input  logic                                  trig_valid,
  input  trigger_mode_t [channels-1:0]          trig_modes,
  input  logic                                  burst_valid,
  input  logic [channels-1:0][burst_width-1:0]  burst_lengths,
  input  logic                                  start,
  input  logic                                  stop,
  input  logic                                  in_valid,
  input  logic                                  in_last,
  input  sample_word_t                          in_data,
  input  logic                                  status_ack,
  output logic                                  cfg_ready,
  output logic                                  in_ready,
  output transfer_status_t                      status,
  output logic                                  status_valid,
  output sample_word_t [channels-1:0]           dac_data,
  output logic                                  dac_valid,
  output logic [channels-1:0]                   dac_trigger
);

  write_port_t                         wr;
  channel_cfg_t [channels-1:0]         cfg;
  logic [channels-1:0][addr_width-1:0] read_addr;
  logic [channels-1:0]                 zero_mask;
  logic                                play_done;
  logic                                play_start;

  // no playback while the memories are being filled
  assign play_start = start & ~in_ready;

  awg_loader loader_i (
    .dac_clk       (dac_clk),
    .dma_reset     (dma_reset),
    .depth_valid   (depth_valid),
    .depth_lengths (depth_lengths),
    .trig_valid    (trig_valid),
    .trig_modes    (trig_modes),
    .burst_valid   (burst_valid),
    .burst_lengths (burst_lengths),
    .stop          (stop),
    .play_done     (play_done),
    .in_valid      (in_valid),
    .in_last       (in_last),
    .in_data       (in_data),
    .cfg_ready     (cfg_ready),
    .in_ready      (in_ready),
    .wr            (wr),
    .cfg           (cfg),
    .status        (status),
    .status_valid  (status_valid),
    .status_ack    (status_ack)
  );

  awg_sample_buffer buffer_i (
    .dac_clk   (dac_clk),
    .wr        (wr),
    .read_addr (read_addr),
    .zero_mask (zero_mask),
    .dac_data  (dac_data)
  );

  awg_playback playback_i (
    .dac_clk     (dac_clk),
    .dma_reset   (dma_reset),
    .start       (play_start),
    .stop        (stop),
    .cfg         (cfg),
    .read_addr   (read_addr),
    .zero_mask   (zero_mask),
    .dac_trigger (dac_trigger),
    .dac_valid   (dac_valid),
    .play_done   (play_done)
  );

endmodule

/* verification/awg_checker.sv */
// awg protocol checker
// concurrent assertions on the loader ready levels, the trigger output
// before the first load and the status acknowledge

`timescale 1ns/1ps

module awg_checker import awg_pkg::*; (
  input logic                dac_clk,
  input logic                dma_reset,
  input logic                depth_valid,
  input logic                cfg_ready,
  input logic                in_ready,
  input logic [channels-1:0] dac_trigger,
  input logic                status_ack,
  input logic                status_valid
);

  // failed assertions, read back by the testbench at the end
  int unsigned fail_count = 0;
  // set once the loader has taken its first depth strobe
  logic        loaded;

  always_ff @(posedge dac_clk) begin
    if (dma_reset) begin
      loaded <= 1'b0;
    end else if (depth_valid && cfg_ready) begin
      loaded <= 1'b1;
    end
  end

  // loader is idle or accepting, never both
  ready_exclusive: assert property (
    @(posedge dac_clk) disable iff (dma_reset) !(in_ready && cfg_ready)
  ) else begin
    $error("in_ready and cfg_ready high together");
    fail_count++;
  end

  // nothing loaded yet, so no trigger can fire
  trigger_quiet: assert property (
    @(posedge dac_clk) disable iff (dma_reset) !loaded |-> (dac_trigger == '0)
  ) else begin
    $error("dac_trigger pulsed before any waveform was loaded");
    fail_count++;
  end

  // ack drops status_valid at the next edge
  ack_clears_valid: assert property (
    @(posedge dac_clk) disable iff (dma_reset) status_ack |=> !status_valid
  ) else begin
    $error("status_valid still high after status_ack");
    fail_count++;
  end

endmodule

bind awg_top awg_checker checker_i (
  .dac_clk      (dac_clk),
  .dma_reset    (dma_reset),
  .depth_valid  (depth_valid),
  .cfg_ready    (cfg_ready),
  .in_ready     (in_ready),
  .dac_trigger  (dac_trigger),
  .status_ack   (status_ack),
  .status_valid (status_valid)
);

/* verification/awg_tb.sv */
// awg testbench
// reads commands, waveform words and expected status from the stimulus
// file, drives the core on the falling clock edge and predicts each
// channel's output stream and trigger pulses from the load and playback rules

`timescale 1ns/1ps

module awg_tb import awg_pkg::*; ();

  // DUT inputs
  logic                                 dac_clk;
  logic                                 dma_reset;
  logic                                 depth_valid;
  logic [channels-1:0][depth_width-1:0] depth_lengths;
  logic                                 trig_valid;
  trigger_mode_t [channels-1:0]         trig_modes;
  logic                                 burst_valid;
  logic [channels-1:0][burst_width-1:0] burst_lengths;
  logic                                 start;
  logic                                 stop;
  logic                                 in_valid;
  logic                                 in_last;
  sample_word_t                         in_data;
  logic                                 status_ack;
  // DUT outputs
  logic                                 cfg_ready;
  logic                                 in_ready;
  transfer_status_t                     status;
  logic                                 status_valid;
  sample_word_t [channels-1:0]          dac_data;
  logic                                 dac_valid;
  logic [channels-1:0]                  dac_trigger;

  // reference copy of the sample memories and channel settings
  sample_word_t  model_mem [channels][depth];
  int            len_q [channels];
  int            burst_q [channels];
  trigger_mode_t mode_q [channels];
  int            wr_chan;
  int            wr_addr;
  // loader closed its transfer and waits for playback end or stop
  logic          load_blocked;
  // four words per record of test, command, a and b
  logic [31:0]   stim [256];
  string         test_label;
  int            cycles = 0;
  int            cycle_limit;

  awg_top dut (.*);

  initial begin
    dac_clk = 1'b0;
    forever #20 dac_clk = ~dac_clk;
  end

  // run limit
  always @(posedge dac_clk) begin
    cycles = cycles + 1;
    if (cycles > cycle_limit) begin
      fail_run($sformatf("timeout after %0d cycles in %s", cycles, test_label));
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////////////////////

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_word(input string what, input sample_word_t exp,
                            input sample_word_t act);
    if (act !== exp) begin
      fail_run($sformatf("error: %s %s expected %h actual %h", test_label, what, exp, act));
    end
  endtask

  task automatic check_status(input transfer_status_t exp, input transfer_status_t act);
    if (act !== exp) begin
      fail_run($sformatf("error: %s status expected %b actual %b", test_label, exp, act));
    end
  endtask

  task automatic check_trigger(input int k, input logic [channels-1:0] exp,
                               input logic [channels-1:0] act);
    if (act !== exp) begin
      fail_run($sformatf("error: %s dac_trigger cycle %0d expected %b actual %b",
                         test_label, k, exp, act));
    end
  endtask

  task automatic check_flag(input string what, input logic exp, input logic act);
    if (act !== exp) begin
      fail_run($sformatf("error: %s %s expected %b actual %b", test_label, what, exp, act));
    end
  endtask

  function automatic string test_name(input logic [31:0] n);
    case (n)
      32'd1:   return "load_last";
      32'd2:   return "burst_play";
      32'd3:   return "trigger_modes";
      32'd4:   return "transfer_status";
      32'd5:   return "stop_burst";
      default: return "unnamed";
    endcase
  endfunction

  // handshakes per command plus every played burst and a margin
  function automatic int cycles_needed();
    int total;
    int span;
    int lens [channels];
    int bursts [channels];
    total = 40;
    for (int ch = 0; ch < channels; ch++) begin
      lens[ch]   = 1;
      bursts[ch] = 1;
    end
    for (int r = 0; r < 64; r++) begin
      if (stim[4*r+1] == 0) break;
      total += 8;
      case (stim[4*r+1])
        32'd2: begin
          bursts[0] = int'(stim[4*r+2]);
          bursts[1] = int'(stim[4*r+3]);
        end
        32'd3: begin
          lens[0] = int'(stim[4*r+2]);
          lens[1] = int'(stim[4*r+3]);
        end
        32'd6: begin
          span = 0;
          for (int ch = 0; ch < channels; ch++) begin
            if (lens[ch] * bursts[ch] > span) span = lens[ch] * bursts[ch];
          end
          total += (stim[4*r+2] != 0) ? int'(stim[4*r+2]) : span + read_latency + 8;
        end
        default: ;
      endcase
    end
    return total;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // command tasks start and end on a falling edge
  ////////////////////////////////////////////////////////////////////////////

  task automatic wait_cfg_ready();
    while (!cfg_ready) @(negedge dac_clk);
  endtask

  // op 1 trigger modes, op 2 burst lengths, op 3 depth lengths
  task automatic write_config(input logic [31:0] op, input logic [31:0] a,
                              input logic [31:0] b);
    wait_cfg_ready();
    case (op)
      32'd1: begin
        trig_modes[0] = trigger_mode_t'(a[1:0]);
        trig_modes[1] = trigger_mode_t'(b[1:0]);
        mode_q[0]     = trig_modes[0];
        mode_q[1]     = trig_modes[1];
        trig_valid    = 1'b1;
      end
      32'd2: begin
        burst_lengths[0] = a[burst_width-1:0];
        burst_lengths[1] = b[burst_width-1:0];
        burst_q[0]       = int'(a);
        burst_q[1]       = int'(b);
        burst_valid      = 1'b1;
      end
      default: begin
        depth_lengths[0] = a[depth_width-1:0];
        depth_lengths[1] = b[depth_width-1:0];
        len_q[0]         = int'(a);
        len_q[1]         = int'(b);
        // new transfer refills from channel 0, address 0
        wr_chan          = 0;
        wr_addr          = 0;
        depth_valid      = 1'b1;
      end
    endcase
    @(negedge dac_clk);
    trig_valid  = 1'b0;
    burst_valid = 1'b0;
    depth_valid = 1'b0;
  endtask

  task automatic send_word(input sample_word_t data, input logic last);
    while (!in_ready) @(negedge dac_clk);
    in_valid = 1'b1;
    in_data  = data;
    in_last  = last;
    @(negedge dac_clk);
    in_valid = 1'b0;
    in_last  = 1'b0;
    // words fill addresses first, then move on to the next channel
    if (wr_chan < channels) begin
      // a last flag or the final address of the last channel closes the load
      if (last || (wr_chan == channels - 1 && wr_addr == len_q[wr_chan] - 1)) begin
        load_blocked = 1'b1;
      end
      model_mem[wr_chan][wr_addr] = data;
      if (wr_addr == len_q[wr_chan] - 1) begin
        wr_addr = 0;
        wr_chan++;
      end else begin
        wr_addr++;
      end
    end
  endtask

  task automatic expect_status(input logic [31:0] a, input logic [31:0] b);
    transfer_status_t exp;
    exp.early_last   = a[0];
    exp.missing_last = b[0];
    while (!status_valid) @(negedge dac_clk);
    check_status(exp, status);
    status_ack = 1'b1;
    @(negedge dac_clk);
    status_ack = 1'b0;
    check_flag("status_valid after ack", 1'b0, status_valid);
  endtask

  // cut of 0 plays to the end, otherwise checks only that many cycles
  task automatic play(input int cut);
    int                  total [channels];
    int                  span;
    int                  idx;
    int                  last_k;
    sample_word_t        exp_word;
    logic [channels-1:0] exp_trig;
    span = 0;
    for (int ch = 0; ch < channels; ch++) begin
      total[ch] = len_q[ch] * burst_q[ch];
      if (total[ch] > span) span = total[ch];
    end
    last_k = (cut > 0) ? cut - 1 : read_latency + span;
    // a blocking loader keeps cfg_ready low until playback ends
    check_flag("cfg_ready before start", !load_blocked, cfg_ready);
    start = 1'b1;
    for (int k = 0; k <= last_k; k++) begin
      @(negedge dac_clk);
      start    = 1'b0;
      exp_trig = '0;
      for (int ch = 0; ch < channels; ch++) begin
        idx      = k - read_latency;
        exp_word = '0;
        if (idx >= 0 && idx < total[ch]) begin
          exp_word = model_mem[ch][idx % len_q[ch]];
          // first word of a frame carries the trigger
          if (idx % len_q[ch] == 0) begin
            if (mode_q[ch] == trig_every_frame) exp_trig[ch] = 1'b1;
            if (mode_q[ch] == trig_first_frame && idx == 0) exp_trig[ch] = 1'b1;
          end
        end
        check_word($sformatf("dac_data[%0d] cycle %0d", ch, k), exp_word, dac_data[ch]);
      end
      check_trigger(k, exp_trig, dac_trigger);
      check_flag("dac_valid", 1'b1, dac_valid);
      if (load_blocked && k <= span) begin
        check_flag("cfg_ready during playback", 1'b0, cfg_ready);
      end
    end
    if (cut == 0) begin
      wait_cfg_ready();
      load_blocked = 1'b0;
    end
  endtask

  // outputs drain through the read path, then stay zero
  task automatic stop_play();
    stop = 1'b1;
    @(negedge dac_clk);
    stop = 1'b0;
    load_blocked = 1'b0;
    repeat (read_latency) @(negedge dac_clk);
    for (int ch = 0; ch < channels; ch++) begin
      check_word($sformatf("dac_data[%0d] after stop", ch), '0, dac_data[ch]);
    end
    check_trigger(0, '0, dac_trigger);
    check_flag("cfg_ready after stop", 1'b1, cfg_ready);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int          r;
    logic [31:0] op;
    logic [31:0] arg_a;
    logic [31:0] arg_b;
    dma_reset     = 1'b1;
    depth_valid   = 1'b0;
    depth_lengths = '0;
    trig_valid    = 1'b0;
    burst_valid   = 1'b0;
    burst_lengths = '0;
    start         = 1'b0;
    stop          = 1'b0;
    in_valid      = 1'b0;
    in_last       = 1'b0;
    in_data       = '0;
    status_ack    = 1'b0;
    for (int ch = 0; ch < channels; ch++) begin
      trig_modes[ch] = trig_off;
      mode_q[ch]     = trig_off;
      len_q[ch]      = 1;
      burst_q[ch]    = 1;
    end
    wr_chan      = 0;
    wr_addr      = 0;
    load_blocked = 1'b0;
    test_label   = "reset";
    $readmemh("verification/awg_stimulus.txt", stim);
    cycle_limit = cycles_needed();

    repeat (5) @(posedge dac_clk);
    @(negedge dac_clk);
    dma_reset = 1'b0;
    check_flag("cfg_ready", 1'b1, cfg_ready);
    check_flag("in_ready", 1'b0, in_ready);
    check_flag("status_valid", 1'b0, status_valid);
    check_trigger(0, '0, dac_trigger);
    for (int ch = 0; ch < channels; ch++) begin
      check_word($sformatf("dac_data[%0d]", ch), '0, dac_data[ch]);
    end
    // dac_valid follows reset release by three edges
    repeat (2) @(negedge dac_clk);
    check_flag("dac_valid", 1'b0, dac_valid);
    @(negedge dac_clk);
    check_flag("dac_valid", 1'b1, dac_valid);

    r = 0;
    while (r < 64 && stim[4*r+1] != 0) begin
      test_label = test_name(stim[4*r]);
      op         = stim[4*r+1];
      arg_a      = stim[4*r+2];
      arg_b      = stim[4*r+3];
      case (op)
        32'd1, 32'd2, 32'd3: write_config(op, arg_a, arg_b);
        32'd4:   send_word(arg_a, arg_b[0]);
        32'd5:   expect_status(arg_a, arg_b);
        32'd6:   play(int'(arg_a));
        32'd7:   stop_play();
        default: fail_run($sformatf("unknown command %0h in stimulus record %0d", op, r));
      endcase
      r++;
    end
    if (r == 0) begin
      fail_run("stimulus file holds no commands");
    end

    if (dut.checker_i.fail_count != 0) begin
      fail_run($sformatf("%0d protocol assertions failed", dut.checker_i.fail_count));
    end else begin
      $display("Test completed successfully");
      $finish;
    end
  end

endmodule

/* verification/awg_stimulus.txt */
// columns: test op a b (hex); op 1 trig modes, 2 burst lengths, 3 depth lengths (ch0 ch1)
// op 4 word data/last, 5 status early/missing, 6 play a cycles (0 runs to the end), 7 stop
1 1 0 0
1 2 2 3
1 3 5 3
1 4 a0010001 0
1 4 a0020002 0
1 4 a0030003 0
1 4 a0040004 0
1 4 a0050005 0
1 4 b1010101 0
1 4 b1020102 0
1 4 b1030103 1
1 5 0 0
2 6 0 0
3 1 1 2
3 6 0 0
4 3 5 3
4 4 c0010001 0
4 4 c0020002 1
4 5 1 0
4 7 0 0
4 3 2 1
4 4 d0010001 0
4 4 d0020002 0
4 4 d1010101 0
4 5 0 1
4 7 0 0
5 2 c8 c8
5 6 14 0
5 7 0 0
0 0 0 0

/* sources.f */
rtl/awg_pkg.sv
rtl/awg_loader.sv
rtl/awg_sample_buffer.sv
rtl/awg_playback.sv
rtl/awg_top.sv
verification/awg_checker.sv
verification/awg_tb.sv

/* Makefile */
# Verilator build and run of the awg testbench

VERILATOR ?= verilator
TOP       ?= awg_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Test completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
